// ==== verilog/ymPkg.sv ====
package ymPkg;

	// Part A register map
	localparam logic [7:0] regSsgFreqALo = 8'h00;
	localparam logic [7:0] regSsgFreqAHi = 8'h01;
	localparam logic [7:0] regSsgFreqBLo = 8'h02;
	localparam logic [7:0] regSsgFreqBHi = 8'h03;
	localparam logic [7:0] regSsgFreqCLo = 8'h04;
	localparam logic [7:0] regSsgFreqCHi = 8'h05;
	localparam logic [7:0] regSsgEnable = 8'h07;
	localparam logic [7:0] regSsgVolA = 8'h08;
	localparam logic [7:0] regSsgVolB = 8'h09;
	localparam logic [7:0] regSsgVolC = 8'h0A;
	localparam logic [7:0] regTimerALo = 8'h24;
	localparam logic [7:0] regTimerAHi = 8'h25;
	localparam logic [7:0] regTimerB = 8'h26;
	localparam logic [7:0] regTimerConfig = 8'h27;

	// Bits of the timer config register
	localparam int cfgLoadA = 0;
	localparam int cfgLoadB = 1;
	localparam int cfgIrqA = 2;
	localparam int cfgIrqB = 3;
	localparam int cfgResetA = 4;
	localparam int cfgResetB = 5;

	// Clock dividers
	localparam int timerPrescale = 72;
	localparam int timerBDivide = 16;
	localparam int ssgPrescale = 8;

	localparam int timerPreW = $clog2(timerPrescale);
	localparam int timerDivW = $clog2(timerBDivide);
	localparam int ssgPreW = $clog2(ssgPrescale);

	typedef logic [9:0] timerACountT;
	typedef logic [7:0] timerBCountT;
	typedef logic [11:0] toneCountT;

	// Bit 4 selects envelope mode
	typedef logic [4:0] volT;

endpackage

// ==== verilog/ymReloadCounter.sv ====
module ymReloadCounter #(
	parameter type countT = logic [7:0]
) (
	input logic PHI_S,
	input logic nRESET,
	input logic run,
	input logic tick,
	input countT reload,
	output logic wrap
);

	countT count;

	// Period is reload + 1 ticks
	always_ff @(posedge PHI_S)
	begin
		if (!nRESET)
		begin
			count <= '0;
			wrap <= 1'b0;
		end
		else
		begin
			wrap <= 1'b0;
			if (!run)
				count <= reload;
			else if (tick)
			begin
				if (count == '0)
				begin
					count <= reload;
					wrap <= 1'b1;
				end
				else
					count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== verilog/ymRegs.sv ====
module ymRegs import ymPkg::*; (
	input logic PHI_S,
	input logic nRESET,
	input logic nWRITE_S,
	input logic [1:0] ADDR_S,
	input logic [7:0] DATA_S,
	output logic busy,

	output toneCountT ssgFreqA,
	output toneCountT ssgFreqB,
	output toneCountT ssgFreqC,
	output logic [5:0] ssgEnable,
	output volT ssgVolA,
	output volT ssgVolB,
	output volT ssgVolC,

	output timerACountT timerALoad,
	output timerBCountT timerBLoad,
	output logic [7:0] timerConfig,
	output logic configWritten
);

	logic [7:0] addrA;
	logic [7:0] addrB;
	logic accept;

	// One write per low phase of nWRITE_S
	assign accept = !nWRITE_S && !busy;

	always_ff @(posedge PHI_S)
	begin
		if (!nRESET)
			busy <= 1'b0;
		else
			busy <= !nWRITE_S;
	end

	// Address latches, bit 1 of ADDR_S picks the part
	always_ff @(posedge PHI_S)
	begin
		if (!nRESET)
		begin
			addrA <= 8'h00;
			addrB <= 8'h00;
		end
		else if (accept && !ADDR_S[0])
		begin
			if (!ADDR_S[1])
				addrA <= DATA_S;
			else
				addrB <= DATA_S;
		end
	end

	// Part A data decode
	always_ff @(posedge PHI_S)
	begin
		if (!nRESET)
		begin
			ssgFreqA <= '0;
			ssgFreqB <= '0;
			ssgFreqC <= '0;
			ssgEnable <= 6'h3F;
			ssgVolA <= '0;
			ssgVolB <= '0;
			ssgVolC <= '0;
			timerALoad <= '0;
			timerBLoad <= '0;
			timerConfig <= 8'h00;
			configWritten <= 1'b0;
		end
		else
		begin
			configWritten <= 1'b0;
			if (accept && ADDR_S[0] && !ADDR_S[1])
			begin
				case (addrA)
					regSsgFreqALo:
						ssgFreqA[7:0] <= DATA_S;
					regSsgFreqAHi:
						ssgFreqA[11:8] <= DATA_S[3:0];
					regSsgFreqBLo:
						ssgFreqB[7:0] <= DATA_S;
					regSsgFreqBHi:
						ssgFreqB[11:8] <= DATA_S[3:0];
					regSsgFreqCLo:
						ssgFreqC[7:0] <= DATA_S;
					regSsgFreqCHi:
						ssgFreqC[11:8] <= DATA_S[3:0];
					regSsgEnable:
						ssgEnable <= DATA_S[5:0];
					regSsgVolA:
						ssgVolA <= DATA_S[4:0];
					regSsgVolB:
						ssgVolB <= DATA_S[4:0];
					regSsgVolC:
						ssgVolC <= DATA_S[4:0];
					regTimerALo:
						timerALoad[7:0] <= DATA_S;
					regTimerAHi:
						timerALoad[9:8] <= DATA_S[1:0];
					regTimerB:
						timerBLoad <= DATA_S;
					regTimerConfig:
					begin
						timerConfig <= DATA_S;
						configWritten <= 1'b1;
					end
					default:
						;
				endcase
			end
			// Part B data goes to the ADPCM units, not present here
		end
	end

endmodule

// ==== verilog/ymTimers.sv ====
module ymTimers import ymPkg::*; (
	input logic PHI_S,
	input logic nRESET,
	input timerACountT timerALoad,
	input timerBCountT timerBLoad,
	input logic [7:0] timerConfig,
	input logic configWritten,
	output logic flagA,
	output logic flagB,
	output logic nIRQ
);

	logic [timerPreW-1:0] preCnt;
	logic [timerDivW-1:0] divCnt;
	logic tickA;
	logic tickB;
	logic wrapA;
	logic wrapB;

	assign tickA = (preCnt == timerPreW'(timerPrescale - 1));
	assign tickB = tickA && (divCnt == timerDivW'(timerBDivide - 1));

	// Free running, so the first tick after a start is partial
	always_ff @(posedge PHI_S)
	begin
		if (!nRESET)
		begin
			preCnt <= '0;
			divCnt <= '0;
		end
		else
		begin
			if (tickA)
			begin
				preCnt <= '0;
				divCnt <= divCnt + 1'b1;
			end
			else
				preCnt <= preCnt + 1'b1;
		end
	end

	// Complemented load gives 1024 - load and 256 - load
	ymReloadCounter #(.countT(timerACountT)) counterA (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.run(timerConfig[cfgLoadA]),
		.tick(tickA),
		.reload(~timerALoad),
		.wrap(wrapA)
	);

	ymReloadCounter #(.countT(timerBCountT)) counterB (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.run(timerConfig[cfgLoadB]),
		.tick(tickB),
		.reload(~timerBLoad),
		.wrap(wrapB)
	);

	always_ff @(posedge PHI_S)
	begin
		if (!nRESET)
		begin
			flagA <= 1'b0;
			flagB <= 1'b0;
			nIRQ <= 1'b1;
		end
		else
		begin
			if (wrapA)
				flagA <= 1'b1;
			else if (configWritten && timerConfig[cfgResetA])
				flagA <= 1'b0;

			if (wrapB)
				flagB <= 1'b1;
			else if (configWritten && timerConfig[cfgResetB])
				flagB <= 1'b0;

			nIRQ <= !((flagA && timerConfig[cfgIrqA]) || (flagB && timerConfig[cfgIrqB]));
		end
	end

endmodule

// ==== verilog/ymSsgTone.sv ====
module ymSsgTone import ymPkg::*; (
	input logic PHI_S,
	input logic nRESET,
	input toneCountT ssgFreqA,
	input toneCountT ssgFreqB,
	input toneCountT ssgFreqC,
	input logic [5:0] ssgEnable,
	input volT ssgVolA,
	input volT ssgVolB,
	input volT ssgVolC,
	output logic [3:0] levelA,
	output logic [3:0] levelB,
	output logic [3:0] levelC
);

	logic [ssgPreW-1:0] preCnt;
	logic tick;
	toneCountT freq [3];
	volT vol [3];
	logic [3:0] level [3];

	assign freq[0] = ssgFreqA;
	assign freq[1] = ssgFreqB;
	assign freq[2] = ssgFreqC;
	assign vol[0] = ssgVolA;
	assign vol[1] = ssgVolB;
	assign vol[2] = ssgVolC;

	assign tick = (preCnt == ssgPreW'(ssgPrescale - 1));

	always_ff @(posedge PHI_S)
	begin
		if (!nRESET)
			preCnt <= '0;
		else
			preCnt <= preCnt + 1'b1;
	end

	for (genvar i = 0; i < 3; i++)
	begin : chan
		toneCountT reload;
		logic wrap;
		logic square;

		// Zero plays like one
		assign reload = (freq[i] == '0) ? '0 : freq[i] - 1'b1;

		ymReloadCounter #(.countT(toneCountT)) counter (
			.PHI_S(PHI_S),
			.nRESET(nRESET),
			.run(!ssgEnable[i]),
			.tick(tick),
			.reload(reload),
			.wrap(wrap)
		);

		always_ff @(posedge PHI_S)
		begin
			if (!nRESET)
			begin
				square <= 1'b0;
				level[i] <= 4'd0;
			end
			else
			begin
				if (wrap)
					square <= !square;
				// Enable is active low
				level[i] <= (!ssgEnable[i] && square) ? vol[i][3:0] : 4'd0;
			end
		end
	end

	assign levelA = level[0];
	assign levelB = level[1];
	assign levelC = level[2];

endmodule

// ==== verilog/ymTop.sv ====
module ymTop import ymPkg::*; (
	input logic PHI_S,
	input logic nRESET,
	input logic nWRITE_S,
	input logic [1:0] ADDR_S,
	input logic [7:0] DATA_S,
	output logic busy,
	output logic flagA,
	output logic flagB,
	output logic nIRQ,
	output logic [3:0] levelA,
	output logic [3:0] levelB,
	output logic [3:0] levelC
);

	toneCountT ssgFreqA;
	toneCountT ssgFreqB;
	toneCountT ssgFreqC;
	logic [5:0] ssgEnable;
	volT ssgVolA;
	volT ssgVolB;
	volT ssgVolC;
	timerACountT timerALoad;
	timerBCountT timerBLoad;
	logic [7:0] timerConfig;
	logic configWritten;

	ymRegs regs (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.nWRITE_S(nWRITE_S),
		.ADDR_S(ADDR_S),
		.DATA_S(DATA_S),
		.busy(busy),
		.ssgFreqA(ssgFreqA),
		.ssgFreqB(ssgFreqB),
		.ssgFreqC(ssgFreqC),
		.ssgEnable(ssgEnable),
		.ssgVolA(ssgVolA),
		.ssgVolB(ssgVolB),
		.ssgVolC(ssgVolC),
		.timerALoad(timerALoad),
		.timerBLoad(timerBLoad),
		.timerConfig(timerConfig),
		.configWritten(configWritten)
	);

	ymTimers timers (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.timerALoad(timerALoad),
		.timerBLoad(timerBLoad),
		.timerConfig(timerConfig),
		.configWritten(configWritten),
		.flagA(flagA),
		.flagB(flagB),
		.nIRQ(nIRQ)
	);

	ymSsgTone tone (
		.PHI_S(PHI_S),
		.nRESET(nRESET),
		.ssgFreqA(ssgFreqA),
		.ssgFreqB(ssgFreqB),
		.ssgFreqC(ssgFreqC),
		.ssgEnable(ssgEnable),
		.ssgVolA(ssgVolA),
		.ssgVolB(ssgVolB),
		.ssgVolC(ssgVolC),
		.levelA(levelA),
		.levelB(levelB),
		.levelC(levelC)
	);

endmodule

// ==== dv/tbYmModel.svh ====
`ifndef TB_YM_MODEL_SVH
`define TB_YM_MODEL_SVH

// Shadow of the part A register map
logic [7:0] shadowA [256];
logic [7:0] modelAddrA;

task automatic modelReset();
	for (int i = 0; i < 256; i++)
		shadowA[i] = 8'h00;
	shadowA[regSsgEnable] = 8'h3F;
	modelAddrA = 8'h00;
endtask

// Part B and unmapped part A data land nowhere visible
task automatic modelWrite(input logic [1:0] port, input logic [7:0] data);
	if (port == 2'd0)
		modelAddrA = data;
	else if (port == 2'd1)
		shadowA[modelAddrA] = data;
endtask

function automatic int tonePeriod(input int ch);
	int f;
	f = int'({shadowA[2 * ch + 1][3:0], shadowA[2 * ch]});
	return ((f == 0) ? 1 : f) * ssgPrescale;
endfunction

function automatic int toneVol(input int ch);
	return int'(shadowA[int'(regSsgVolA) + ch][3:0]);
endfunction

function automatic bit toneOn(input int ch);
	return !shadowA[regSsgEnable][ch];
endfunction

function automatic int timerAPeriod();
	return (1024 - int'({shadowA[regTimerAHi][1:0], shadowA[regTimerALo]})) * timerPrescale;
endfunction

function automatic int timerBPeriod();
	return (256 - int'(shadowA[regTimerB])) * timerPrescale * timerBDivide;
endfunction

function automatic int irqLevel(input bit fa, input bit fb);
	return int'(!((fa && shadowA[regTimerConfig][cfgIrqA]) ||
		(fb && shadowA[regTimerConfig][cfgIrqB])));
endfunction

`endif

// ==== dv/tbYmTop.sv ====
module tbYmTop import ymPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic PHI_S;
	logic nRESET;
	logic nWRITE_S;
	logic [1:0] ADDR_S;
	logic [7:0] DATA_S;
	logic busy;
	logic flagA;
	logic flagB;
	logic nIRQ;
	logic [3:0] levelA;
	logic [3:0] levelB;
	logic [3:0] levelC;

	int cycle = 0;
	int lastAccept;
	int passCount = 0;
	int failCount = 0;
	int budget = 0;
	logic [31:0] rngState = 32'd85689;

	`include "tbYmModel.svh"

	ymTop uut (.*);

	initial
	begin
		PHI_S = 1'b0;
		forever
			#50 PHI_S = !PHI_S;
	end

	always @(posedge PHI_S)
		cycle <= cycle + 1;

	function automatic int randRange(input int lo, input int hi);
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return lo + int'(rngState % 32'(hi - lo + 1));
	endfunction

	task automatic checkValue(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
			failCount++;
		end
		else
			passCount++;
	endtask

	task automatic writeBus(input logic [1:0] port, input logic [7:0] data);
		int waited;
		@(posedge PHI_S);
		nWRITE_S <= 1'b0;
		ADDR_S <= port;
		DATA_S <= data;
		waited = 0;
		do
		begin
			@(negedge PHI_S);
			waited++;
		end
		while (!busy && waited < 16);
		if (!busy)
		begin
			$display("Write to port %0d was never accepted, busy stayed low", port);
			failCount++;
		end
		lastAccept = cycle;
		@(posedge PHI_S);
		nWRITE_S <= 1'b1;
		@(negedge PHI_S);
		@(negedge PHI_S);
		checkValue("busy release", 0, int'(busy));
		modelWrite(port, data);
	endtask

	task automatic writeReg(input logic [7:0] addr, input logic [7:0] data);
		writeBus(2'd0, addr);
		writeBus(2'd1, data);
	endtask

	// Returns the cycle of the rise, or -1
	task automatic waitRise(input bit useB, input int limit, output int when);
		when = -1;
		for (int i = 0; i < limit && when < 0; i++)
		begin
			@(negedge PHI_S);
			if (useB ? flagB : flagA)
				when = cycle;
		end
		if (when < 0)
		begin
			$display("Timer flag %s never rose", useB ? "B" : "A");
			failCount++;
		end
	endtask

	task automatic monitorTones(input int cycles);
		logic [3:0] lv;
		logic [3:0] prev [3];
		int lastEdge [3];
		int edges [3];
		for (int ch = 0; ch < 3; ch++)
		begin
			prev[ch] = (ch == 0) ? levelA : (ch == 1) ? levelB : levelC;
			edges[ch] = 0;
			lastEdge[ch] = 0;
		end
		repeat (cycles)
		begin
			@(negedge PHI_S);
			for (int ch = 0; ch < 3; ch++)
			begin
				lv = (ch == 0) ? levelA : (ch == 1) ? levelB : levelC;
				if (!toneOn(ch) && lv != 4'd0)
					checkValue($sformatf("level%0d disabled", ch), 0, int'(lv));
				else if (lv != 4'd0)
					checkValue($sformatf("level%0d", ch), toneVol(ch), int'(lv));
				if (lv != prev[ch])
				begin
					if (edges[ch] > 0)
						checkValue($sformatf("level%0d spacing", ch), tonePeriod(ch),
							cycle - lastEdge[ch]);
					edges[ch]++;
					lastEdge[ch] = cycle;
				end
				prev[ch] = lv;
			end
		end
		for (int ch = 0; ch < 3; ch++)
			if (toneOn(ch) && toneVol(ch) != 0)
				checkValue($sformatf("level%0d edges seen", ch), 1, int'(edges[ch] >= 3));
	endtask

	function automatic int longestTone();
		int m;
		m = 8;
		for (int ch = 0; ch < 3; ch++)
			if (toneOn(ch) && tonePeriod(ch) > m)
				m = tonePeriod(ch);
		return 4 * m + 40;
	endfunction

	task automatic programTones(input logic [2:0] offMask);
		writeReg(regSsgEnable, 8'h3F);
		for (int ch = 0; ch < 3; ch++)
		begin
			writeReg(8'(2 * ch), 8'(randRange(1, 40)));
			writeReg(8'(2 * ch + 1), 8'h00);
			writeReg(8'(int'(regSsgVolA) + ch), 8'(16 * randRange(0, 1) + randRange(1, 15)));
		end
		writeReg(regSsgEnable, {5'b11111, offMask});
	endtask

	task automatic reportTest(input string name);
		$display("%s done, failed checks so far %0d", name, failCount);
	endtask

	initial
	begin
		int loadA;
		int loadB;
		int rise1;
		int rise2;
		int hold;
		int v1;
		nRESET = 1'b0;
		nWRITE_S = 1'b1;
		ADDR_S = 2'd0;
		DATA_S = 8'h00;
		modelReset();
		loadA = randRange(1000, 1023);
		loadB = randRange(250, 255);
		budget = 9000 + 3 * (1025 - loadA) * timerPrescale +
			(257 - loadB) * timerPrescale * timerBDivide + 4 * 300 * 8;

		// Reset state
		repeat (10)
		begin
			@(negedge PHI_S);
			checkValue("busy", 0, int'(busy));
			checkValue("nIRQ", 1, int'(nIRQ));
			checkValue("flags", 0, int'({flagA, flagB}));
			checkValue("levels", 0, int'({levelA, levelB, levelC}));
		end
		@(posedge PHI_S);
		nRESET <= 1'b1;
		@(negedge PHI_S);
		checkValue("busy", 0, int'(busy));
		checkValue("levels", 0, int'({levelA, levelB, levelC}));
		reportTest("reset");

		// Held write where the second data must not land
		writeBus(2'd0, regSsgVolA);
		v1 = randRange(1, 15);
		hold = randRange(2, 12);
		@(posedge PHI_S);
		nWRITE_S <= 1'b0;
		ADDR_S <= 2'd1;
		DATA_S <= 8'(v1);
		@(negedge PHI_S);
		checkValue("busy before accept", 0, int'(busy));
		@(negedge PHI_S);
		checkValue("busy after accept", 1, int'(busy));
		@(posedge PHI_S);
		DATA_S <= 8'(v1 ^ randRange(1, 15));
		repeat (hold)
		begin
			@(negedge PHI_S);
			checkValue("busy held", 1, int'(busy));
		end
		@(posedge PHI_S);
		nWRITE_S <= 1'b1;
		@(negedge PHI_S);
		checkValue("busy held", 1, int'(busy));
		@(negedge PHI_S);
		checkValue("busy release", 0, int'(busy));
		modelWrite(2'd1, 8'(v1));
		writeReg(regSsgFreqALo, 8'd2);
		writeReg(regSsgEnable, 8'h3E);
		monitorTones(100);
		reportTest("handshake");

		programTones(3'(randRange(0, 6)));
		monitorTones(longestTone());
		reportTest("tone");

		// Timer A
		writeReg(regTimerConfig, 8'h30);
		writeReg(regTimerALo, 8'(loadA));
		writeReg(regTimerAHi, 8'(loadA >> 8));
		writeReg(regTimerConfig, 8'h01);
		waitRise(1'b0, timerAPeriod() + 200, rise1);
		checkValue("flagA first rise in window", 1,
			int'(rise1 - lastAccept >= timerAPeriod() - timerPrescale &&
			rise1 - lastAccept <= timerAPeriod() + timerPrescale + 4));
		writeReg(regTimerConfig, 8'h11);
		checkValue("flagA cleared", 0, int'(flagA));
		waitRise(1'b0, timerAPeriod() + 200, rise2);
		checkValue("flagA period", timerAPeriod(), rise2 - rise1);
		writeReg(regTimerConfig, 8'h10);
		reportTest("timerA");

		// Timer B with the interrupt on A only at first
		writeReg(regTimerB, 8'(loadB));
		writeReg(regTimerConfig, 8'h06);
		waitRise(1'b1, timerBPeriod() + 2000, rise1);
		checkValue("flagB first rise in window", 1,
			int'(rise1 - lastAccept >= timerBPeriod() - timerPrescale * timerBDivide &&
			rise1 - lastAccept <= timerBPeriod() + timerPrescale * timerBDivide + 4));
		repeat (4)
			@(negedge PHI_S);
		checkValue("nIRQ", irqLevel(1'b0, 1'b1), int'(nIRQ));
		writeReg(regTimerConfig, 8'h0A);
		checkValue("nIRQ", irqLevel(1'b0, 1'b1), int'(nIRQ));
		writeReg(regTimerConfig, 8'h28);
		@(negedge PHI_S);
		checkValue("flagB cleared", 0, int'(flagB));
		checkValue("nIRQ", irqLevel(1'b0, 1'b0), int'(nIRQ));
		reportTest("timerB");

		// Stray writes then a new high frequency byte
		programTones(3'(randRange(0, 3) * 2));
		for (int i = 0; i < 5; i++)
		begin
			writeBus(2'd2, 8'(randRange(0, 255)));
			writeBus(2'd3, 8'(randRange(0, 255)));
			writeReg(8'(randRange(40, 255)), 8'(randRange(0, 255)));
		end
		writeReg(8'h06, 8'(randRange(0, 255)));
		monitorTones(longestTone());
		checkValue("flags", 0, int'({flagA, flagB}));
		checkValue("nIRQ", 1, int'(nIRQ));
		writeReg(regSsgFreqAHi, 8'h01);
		monitorTones(longestTone());
		reportTest("decode");

		$display("checks passed %0d failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Budget is set at time zero from the chosen loads
	initial
	begin
		#1;
		#(budget * 100);
		$display("Watchdog expired before the tests finished");
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+dv
verilog/ymPkg.sv
verilog/ymReloadCounter.sv
verilog/ymRegs.sv
verilog/ymTimers.sv
verilog/ymSsgTone.sv
verilog/ymTop.sv
dv/tbYmTop.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tbYmTop -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Build failed"
	exit 1
fi

./obj_dir/VtbYmTop > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "No pass line in sim.log"
	exit 1
fi
exit 0
